//--- hdl/etx_emesh_pkg.sv
package etx_emesh_pkg;

   // Mesh transaction fields
   typedef logic [1:0]  datamode_t;      // Transfer size code
   typedef logic [3:0]  ctrlmode_t;      // Control mode bits
   typedef logic [31:0] addr_t;          // Destination or source address
   typedef logic [31:0] data_t;          // Payload word

   // Channel that a transaction was queued on
   typedef enum logic [1:0]
   {
      CH_WR = 2'd0,                      // Write channel
      CH_RQ = 2'd1,                      // Read request channel
      CH_RR = 2'd2                       // Read response channel
   } chan_t;

   // Stored transaction width
   // Holds write, datamode, ctrlmode, dstaddr, data and srcaddr
   localparam int EMESH_W = 1                   // Write bit
                          + $bits(datamode_t)   // Datamode
                          + $bits(ctrlmode_t)   // Ctrlmode
                          + $bits(addr_t)       // Dstaddr
                          + $bits(data_t)       // Data
                          + $bits(addr_t);      // Srcaddr

endpackage

//--- hdl/etx_link_pkg.sv
package etx_link_pkg;

   // One parallel beat on the link
   typedef logic [63:0] link_data_t;     // Eight bytes, byte 7 sent first
   typedef logic [7:0]  link_frame_t;    // One frame flag per byte

   // Command byte, first byte of beat 0
   typedef struct packed
   {
      logic [3:0] ctrlmode;              // Bits 7..4
      logic [1:0] datamode;              // Bits 3..2
      logic       write;                 // Bit 1
      logic       rsvd;                  // Bit 0, always zero
   } cmd_byte_t;

   // Frame levels
   localparam link_frame_t FRAME_ON  = 8'hff;   // All bytes framed
   localparam link_frame_t FRAME_OFF = 8'h00;   // Idle link

endpackage

//--- hdl/etx_fifo.sv
`timescale 1ns/1ps

module etx_fifo
   import etx_emesh_pkg::*;
#(
   parameter int FIFO_DEPTH      = 8,    // Entries, power of two
   parameter int PROG_FULL_LEVEL = 6     // Occupancy that raises progfull
)
(
   input  logic      tx_lclk_par,
   input  logic      rst,
   input  logic      access,             // Push strobe
   input  logic      write,
   input  datamode_t datamode,
   input  ctrlmode_t ctrlmode,
   input  addr_t     dstaddr,
   input  data_t     data,
   input  addr_t     srcaddr,
   input  logic      pop,                // Removes head at this edge
   output logic      valid,              // Head holds an entry
   output logic      progfull,
   output logic      head_write,
   output datamode_t head_datamode,
   output ctrlmode_t head_ctrlmode,
   output addr_t     head_dstaddr,
   output data_t     head_data,
   output addr_t     head_srcaddr
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = PTR_W + 1;     // Count reaches FIFO_DEPTH

   logic [EMESH_W-1:0] mem [FIFO_DEPTH]; // Entry storage
   logic [EMESH_W-1:0] wr_entry;         // Packed incoming transaction
   logic [EMESH_W-1:0] head_entry;       // Packed entry at read pointer
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;            // Current occupancy
   logic [CNT_W-1:0]   count_nxt;
   logic               full;
   logic               do_wr;
   logic               do_rd;

   assign wr_entry = {write, datamode, ctrlmode, dstaddr, data, srcaddr};

   assign full  = (count == CNT_W'(FIFO_DEPTH));
   assign valid = (count != '0);
   assign do_wr = access & ~full;        // Push into full queue is dropped
   assign do_rd = pop & valid;

   always_comb
   begin
      count_nxt = count;
      if (do_wr && !do_rd)
      begin
         count_nxt = count + 1'b1;       // Grows by one
      end
      else if (do_rd && !do_wr)
      begin
         count_nxt = count - 1'b1;       // Shrinks by one
      end
   end

   // Pointers, count and flag
   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         progfull <= 1'b0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;     // Wraps at depth
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         count    <= count_nxt;
         progfull <= (count_nxt >= CNT_W'(PROG_FULL_LEVEL));  // Registered from next count
      end
   end

   // Storage array
   always_ff @(posedge tx_lclk_par)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_entry;
   end

   // Head falls through from the array
   assign head_entry = mem[rd_ptr];
   assign {head_write, head_datamode, head_ctrlmode,
           head_dstaddr, head_data, head_srcaddr} = head_entry;

endmodule

//--- hdl/etx_arbiter.sv
`timescale 1ns/1ps

module etx_arbiter
   import etx_emesh_pkg::*;
(
   input  logic      tx_lclk_par,
   input  logic      rst,
   input  logic      tx_enable,          // Low stops new grants
   // Write queue head
   input  logic      wr_valid,
   input  logic      wr_write,
   input  datamode_t wr_datamode,
   input  ctrlmode_t wr_ctrlmode,
   input  addr_t     wr_dstaddr,
   input  data_t     wr_data,
   input  addr_t     wr_srcaddr,
   // Read request queue head
   input  logic      rq_valid,
   input  logic      rq_write,
   input  datamode_t rq_datamode,
   input  ctrlmode_t rq_ctrlmode,
   input  addr_t     rq_dstaddr,
   input  data_t     rq_data,
   input  addr_t     rq_srcaddr,
   // Read response queue head
   input  logic      rr_valid,
   input  logic      rr_write,
   input  datamode_t rr_datamode,
   input  ctrlmode_t rr_ctrlmode,
   input  addr_t     rr_dstaddr,
   input  data_t     rr_data,
   input  addr_t     rr_srcaddr,
   input  logic      wr_wait_sync,       // Blocks wr and rr
   input  logic      rd_wait_sync,       // Blocks rq
   input  logic      etx_ack,            // Slot consumed this edge
   output logic      wr_pop,
   output logic      rq_pop,
   output logic      rr_pop,
   output logic      etx_access,         // Slot loaded
   output logic      etx_write,
   output datamode_t etx_datamode,
   output ctrlmode_t etx_ctrlmode,
   output addr_t     etx_dstaddr,
   output data_t     etx_data,
   output addr_t     etx_srcaddr
);

   logic  wr_elig;
   logic  rq_elig;
   logic  rr_elig;
   logic  any_elig;
   logic  slot_free;                     // Empty or emptied this edge
   logic  load;
   chan_t sel_chan;                      // Winning channel

   assign wr_elig  = tx_enable & wr_valid & ~wr_wait_sync;
   assign rq_elig  = tx_enable & rq_valid & ~rd_wait_sync;
   assign rr_elig  = tx_enable & rr_valid & ~wr_wait_sync;  // Responses are writes on the link
   assign any_elig = wr_elig | rq_elig | rr_elig;

   assign slot_free = ~etx_access | etx_ack;
   assign load      = slot_free & any_elig;

   // Fixed priority rr over rq over wr
   always_comb
   begin
      if (rr_elig)
         sel_chan = CH_RR;
      else if (rq_elig)
         sel_chan = CH_RQ;
      else
         sel_chan = CH_WR;
   end

   assign wr_pop = load & (sel_chan == CH_WR);
   assign rq_pop = load & (sel_chan == CH_RQ);
   assign rr_pop = load & (sel_chan == CH_RR);

   // Slot occupancy
   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
         etx_access <= 1'b0;
      else if (slot_free)
         etx_access <= any_elig;         // Refill or go empty
   end

   // Slot payload taken from the popped head
   always_ff @(posedge tx_lclk_par)
   begin
      if (load)
      begin
         case (sel_chan)
            CH_RR:
            begin
               {etx_write, etx_datamode, etx_ctrlmode} <= {rr_write, rr_datamode, rr_ctrlmode};
               {etx_dstaddr, etx_data, etx_srcaddr}    <= {rr_dstaddr, rr_data, rr_srcaddr};
            end
            CH_RQ:
            begin
               {etx_write, etx_datamode, etx_ctrlmode} <= {rq_write, rq_datamode, rq_ctrlmode};
               {etx_dstaddr, etx_data, etx_srcaddr}    <= {rq_dstaddr, rq_data, rq_srcaddr};
            end
            default:
            begin
               {etx_write, etx_datamode, etx_ctrlmode} <= {wr_write, wr_datamode, wr_ctrlmode};
               {etx_dstaddr, etx_data, etx_srcaddr}    <= {wr_dstaddr, wr_data, wr_srcaddr};
            end
         endcase
      end
   end

endmodule

//--- hdl/etx_protocol.sv
`timescale 1ns/1ps

module etx_protocol
   import etx_emesh_pkg::*;
   import etx_link_pkg::*;
(
   input  logic        tx_lclk_par,
   input  logic        rst,
   // Transaction slot from the arbiter
   input  logic        etx_access,
   input  logic        etx_write,
   input  datamode_t   etx_datamode,
   input  ctrlmode_t   etx_ctrlmode,
   input  addr_t       etx_dstaddr,
   input  data_t       etx_data,
   input  addr_t       etx_srcaddr,
   // Back-pressure levels from the far end
   input  logic        tx_wr_wait,
   input  logic        tx_rd_wait,
   output logic        etx_ack,          // Slot taken this edge
   output logic        wr_wait_sync,
   output logic        rd_wait_sync,
   output logic [1:0]  wait_status,      // {wr_wait, rd_wait}
   output link_frame_t tx_frame_par,
   output link_data_t  tx_data_par
);

   logic       wr_wait_meta;             // First sync stage
   logic       rd_wait_meta;
   logic       beat1_pend;               // Beat 1 goes out next edge
   cmd_byte_t  cmd;
   link_data_t beat0;
   link_data_t beat1;
   link_data_t beat1_q;                  // Held second beat

   // Wait level synchronizer
   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
      begin
         wr_wait_meta <= 1'b0;
         rd_wait_meta <= 1'b0;
         wr_wait_sync <= 1'b0;
         rd_wait_sync <= 1'b0;
      end
      else
      begin
         wr_wait_meta <= tx_wr_wait;
         rd_wait_meta <= tx_rd_wait;
         wr_wait_sync <= wr_wait_meta;
         rd_wait_sync <= rd_wait_meta;
      end
   end

   assign wait_status = {wr_wait_sync, rd_wait_sync};   // Readback of wait levels

   // Take a slot unless beat 1 is still owed
   assign etx_ack = etx_access & ~beat1_pend;

   // Command byte layout
   always_comb
   begin
      cmd          = '0;                 // Bit 0 stays zero
      cmd.ctrlmode = etx_ctrlmode;
      cmd.datamode = etx_datamode;
      cmd.write    = etx_write;
   end

   // Beat 0 is cmd, dstaddr, data bytes 3..1
   assign beat0 = {cmd, etx_dstaddr, etx_data[31:8]};
   // Beat 1 is data byte 0, srcaddr, zero pad
   assign beat1 = {etx_data[7:0], etx_srcaddr, 24'h000000};

   // Framer control and output beats
   always_ff @(posedge tx_lclk_par)
   begin
      if (rst)
      begin
         beat1_pend   <= 1'b0;
         tx_frame_par <= FRAME_OFF;
         tx_data_par  <= '0;
      end
      else if (etx_ack)
      begin
         beat1_pend   <= 1'b1;           // Second beat follows
         tx_frame_par <= FRAME_ON;
         tx_data_par  <= beat0;
      end
      else if (beat1_pend)
      begin
         beat1_pend   <= 1'b0;
         tx_frame_par <= FRAME_ON;
         tx_data_par  <= beat1_q;
      end
      else
      begin
         tx_frame_par <= FRAME_OFF;      // Idle link
         tx_data_par  <= '0;
      end
   end

   // Second beat captured with the ack
   always_ff @(posedge tx_lclk_par)
   begin
      if (etx_ack)
         beat1_q <= beat1;
   end

endmodule

//--- hdl/etx_top.sv
`timescale 1ns/1ps

module etx_top
   import etx_emesh_pkg::*;
   import etx_link_pkg::*;
#(
   parameter int FIFO_DEPTH      = 8,    // Entries per queue
   parameter int PROG_FULL_LEVEL = 6     // Progfull threshold per queue
)
(
   input  logic        tx_lclk_par,
   input  logic        rst,
   input  logic        tx_enable,
   // Write channel
   input  logic        wr_access,
   input  logic        wr_write,
   input  datamode_t   wr_datamode,
   input  ctrlmode_t   wr_ctrlmode,
   input  addr_t       wr_dstaddr,
   input  data_t       wr_data,
   input  addr_t       wr_srcaddr,
   // Read request channel
   input  logic        rq_access,
   input  logic        rq_write,
   input  datamode_t   rq_datamode,
   input  ctrlmode_t   rq_ctrlmode,
   input  addr_t       rq_dstaddr,
   input  data_t       rq_data,
   input  addr_t       rq_srcaddr,
   // Read response channel
   input  logic        rr_access,
   input  logic        rr_write,
   input  datamode_t   rr_datamode,
   input  ctrlmode_t   rr_ctrlmode,
   input  addr_t       rr_dstaddr,
   input  data_t       rr_data,
   input  addr_t       rr_srcaddr,
   input  logic        tx_wr_wait,
   input  logic        tx_rd_wait,
   output logic        wr_progfull,
   output logic        rq_progfull,
   output logic        rr_progfull,
   output logic [1:0]  wait_status,
   output link_frame_t tx_frame_par,
   output link_data_t  tx_data_par
);

   // Queue heads and pops
   logic      wr_fifo_valid, rq_fifo_valid, rr_fifo_valid;
   logic      wr_fifo_write, rq_fifo_write, rr_fifo_write;
   datamode_t wr_fifo_datamode, rq_fifo_datamode, rr_fifo_datamode;
   ctrlmode_t wr_fifo_ctrlmode, rq_fifo_ctrlmode, rr_fifo_ctrlmode;
   addr_t     wr_fifo_dstaddr, rq_fifo_dstaddr, rr_fifo_dstaddr;
   data_t     wr_fifo_data, rq_fifo_data, rr_fifo_data;
   addr_t     wr_fifo_srcaddr, rq_fifo_srcaddr, rr_fifo_srcaddr;
   logic      wr_pop, rq_pop, rr_pop;
   // Slot between arbiter and protocol
   logic      etx_access, etx_ack, etx_write;
   datamode_t etx_datamode;
   ctrlmode_t etx_ctrlmode;
   addr_t     etx_dstaddr, etx_srcaddr;
   data_t     etx_data;
   logic      wr_wait_sync, rd_wait_sync;

   etx_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_FULL_LEVEL(PROG_FULL_LEVEL)) wr_fifo_i (
      .tx_lclk_par(tx_lclk_par), .rst(rst), .access(wr_access), .write(wr_write),
      .datamode(wr_datamode), .ctrlmode(wr_ctrlmode), .dstaddr(wr_dstaddr),
      .data(wr_data), .srcaddr(wr_srcaddr), .pop(wr_pop), .valid(wr_fifo_valid),
      .progfull(wr_progfull), .head_write(wr_fifo_write), .head_datamode(wr_fifo_datamode),
      .head_ctrlmode(wr_fifo_ctrlmode), .head_dstaddr(wr_fifo_dstaddr),
      .head_data(wr_fifo_data), .head_srcaddr(wr_fifo_srcaddr));

   etx_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_FULL_LEVEL(PROG_FULL_LEVEL)) rq_fifo_i (
      .tx_lclk_par(tx_lclk_par), .rst(rst), .access(rq_access), .write(rq_write),
      .datamode(rq_datamode), .ctrlmode(rq_ctrlmode), .dstaddr(rq_dstaddr),
      .data(rq_data), .srcaddr(rq_srcaddr), .pop(rq_pop), .valid(rq_fifo_valid),
      .progfull(rq_progfull), .head_write(rq_fifo_write), .head_datamode(rq_fifo_datamode),
      .head_ctrlmode(rq_fifo_ctrlmode), .head_dstaddr(rq_fifo_dstaddr),
      .head_data(rq_fifo_data), .head_srcaddr(rq_fifo_srcaddr));

   etx_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_FULL_LEVEL(PROG_FULL_LEVEL)) rr_fifo_i (
      .tx_lclk_par(tx_lclk_par), .rst(rst), .access(rr_access), .write(rr_write),
      .datamode(rr_datamode), .ctrlmode(rr_ctrlmode), .dstaddr(rr_dstaddr),
      .data(rr_data), .srcaddr(rr_srcaddr), .pop(rr_pop), .valid(rr_fifo_valid),
      .progfull(rr_progfull), .head_write(rr_fifo_write), .head_datamode(rr_fifo_datamode),
      .head_ctrlmode(rr_fifo_ctrlmode), .head_dstaddr(rr_fifo_dstaddr),
      .head_data(rr_fifo_data), .head_srcaddr(rr_fifo_srcaddr));

   etx_arbiter etx_arbiter_i (
      .tx_lclk_par(tx_lclk_par), .rst(rst), .tx_enable(tx_enable),
      .wr_valid(wr_fifo_valid), .wr_write(wr_fifo_write), .wr_datamode(wr_fifo_datamode),
      .wr_ctrlmode(wr_fifo_ctrlmode), .wr_dstaddr(wr_fifo_dstaddr),
      .wr_data(wr_fifo_data), .wr_srcaddr(wr_fifo_srcaddr),
      .rq_valid(rq_fifo_valid), .rq_write(rq_fifo_write), .rq_datamode(rq_fifo_datamode),
      .rq_ctrlmode(rq_fifo_ctrlmode), .rq_dstaddr(rq_fifo_dstaddr),
      .rq_data(rq_fifo_data), .rq_srcaddr(rq_fifo_srcaddr),
      .rr_valid(rr_fifo_valid), .rr_write(rr_fifo_write), .rr_datamode(rr_fifo_datamode),
      .rr_ctrlmode(rr_fifo_ctrlmode), .rr_dstaddr(rr_fifo_dstaddr),
      .rr_data(rr_fifo_data), .rr_srcaddr(rr_fifo_srcaddr),
      .wr_wait_sync(wr_wait_sync), .rd_wait_sync(rd_wait_sync), .etx_ack(etx_ack),
      .wr_pop(wr_pop), .rq_pop(rq_pop), .rr_pop(rr_pop), .etx_access(etx_access),
      .etx_write(etx_write), .etx_datamode(etx_datamode), .etx_ctrlmode(etx_ctrlmode),
      .etx_dstaddr(etx_dstaddr), .etx_data(etx_data), .etx_srcaddr(etx_srcaddr));

   etx_protocol etx_protocol_i (
      .tx_lclk_par(tx_lclk_par), .rst(rst), .etx_access(etx_access),
      .etx_write(etx_write), .etx_datamode(etx_datamode), .etx_ctrlmode(etx_ctrlmode),
      .etx_dstaddr(etx_dstaddr), .etx_data(etx_data), .etx_srcaddr(etx_srcaddr),
      .tx_wr_wait(tx_wr_wait), .tx_rd_wait(tx_rd_wait), .etx_ack(etx_ack),
      .wr_wait_sync(wr_wait_sync), .rd_wait_sync(rd_wait_sync),
      .wait_status(wait_status), .tx_frame_par(tx_frame_par), .tx_data_par(tx_data_par));

endmodule

//--- bench/etx_tb_model.svh
// Expected packets per channel, beat 0 in the upper half
logic [127:0] exp_wr_q[$];
logic [127:0] exp_rq_q[$];
logic [127:0] exp_rr_q[$];
chan_t        rx_log[$];                 // Channel of each received packet
chan_t        order_exp[$];              // Channel order a test expects

// Link packet built from the byte layout of the two beats
function automatic logic [127:0] encode_packet(input logic wr, input datamode_t dm,
   input ctrlmode_t cm, input addr_t dst, input data_t dat, input addr_t src);
   link_data_t b0;
   link_data_t b1;
   b0 = {cm, dm, wr, 1'b0, dst, dat[31:24], dat[23:16], dat[15:8]};
   b1 = {dat[7:0], src, 24'h000000};     // Three pad bytes
   return {b0, b1};
endfunction

// Channel tag from the command byte
function automatic chan_t packet_chan(input link_data_t b0);
   if (!b0[57])
      return CH_RQ;                      // Only requests clear write
   return b0[63] ? CH_RR : CH_WR;        // Ctrlmode bit 3 marks responses
endfunction

function automatic bit model_empty();
   return (exp_wr_q.size() == 0) && (exp_rq_q.size() == 0) && (exp_rr_q.size() == 0);
endfunction

task automatic model_push(input chan_t ch, input logic [127:0] pkt);
   case (ch)
      CH_RR: exp_rr_q.push_back(pkt);
      CH_RQ: exp_rq_q.push_back(pkt);
      default: exp_wr_q.push_back(pkt);
   endcase
endtask

task automatic check_data(input string name, input link_data_t exp, input link_data_t act);
   if (act !== exp)
      fail_stop($sformatf("FAILED %s expected %h got %h", name, exp, act));
endtask

task automatic check_frame(input string name, input link_frame_t exp, input link_frame_t act);
   if (act !== exp)
      fail_stop($sformatf("FAILED %s expected %h got %h", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   if (act !== exp)
      fail_stop($sformatf("FAILED %s expected %h got %h", name, exp, act));
endtask

// Match one received packet with the head of its channel queue
task automatic take_packet(input link_data_t b0, input link_data_t b1);
   chan_t        ch;
   logic [127:0] pkt;
   ch = packet_chan(b0);
   if ((ch == CH_RR && exp_rr_q.size() == 0) || (ch == CH_RQ && exp_rq_q.size() == 0) ||
       (ch == CH_WR && exp_wr_q.size() == 0))
      fail_stop($sformatf("packet arrived on channel %0d with nothing queued there", ch));
   else
   begin
      pkt = (ch == CH_RR) ? exp_rr_q.pop_front() :
            (ch == CH_RQ) ? exp_rq_q.pop_front() : exp_wr_q.pop_front();
      check_data("tx_data_par beat 0", pkt[127:64], b0);
      check_data("tx_data_par beat 1", pkt[63:0], b1);
      rx_log.push_back(ch);
   end
endtask

task automatic check_order();
   if (rx_log.size() != order_exp.size())
      fail_stop($sformatf("%0d packets received where %0d were due",
                          rx_log.size(), order_exp.size()));
   else
      foreach (order_exp[i])
         if (rx_log[i] != order_exp[i])
            fail_stop($sformatf("packet %0d came from channel %0d instead of %0d",
                                i, rx_log[i], order_exp[i]));
endtask

//--- bench/tb_etx_top.sv
`timescale 1ns/1ps

module tb_etx_top
   import etx_emesh_pkg::*;
   import etx_link_pkg::*;
();

   localparam int PROG_LEVEL = 6;        // DUT default threshold
   localparam int TMO        = 2000;     // Cycles per wait loop

   logic        tx_lclk_par;
   logic        rst;
   logic        tx_enable;
   logic        wr_access, rq_access, rr_access;
   logic        in_write;                // Fields shared by all channels
   datamode_t   in_datamode;
   ctrlmode_t   in_ctrlmode;
   addr_t       in_dstaddr, in_srcaddr;
   data_t       in_data;
   logic        tx_wr_wait, tx_rd_wait;
   logic        wr_progfull, rq_progfull, rr_progfull;
   logic [1:0]  wait_status;
   link_frame_t tx_frame_par;
   link_data_t  tx_data_par;
   logic [31:0] lcg_state;
   logic        in_beat1;                // Next framed beat is beat 1
   link_data_t  beat0_hold;
   logic [31:0] r;
   chan_t       ch;

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "simulation stopped at first error");
   endtask

`include "etx_tb_model.svh"

   etx_top dut_i (
      .tx_lclk_par(tx_lclk_par), .rst(rst), .tx_enable(tx_enable),
      .wr_access(wr_access), .wr_write(in_write), .wr_datamode(in_datamode),
      .wr_ctrlmode(in_ctrlmode), .wr_dstaddr(in_dstaddr), .wr_data(in_data),
      .wr_srcaddr(in_srcaddr),
      .rq_access(rq_access), .rq_write(in_write), .rq_datamode(in_datamode),
      .rq_ctrlmode(in_ctrlmode), .rq_dstaddr(in_dstaddr), .rq_data(in_data),
      .rq_srcaddr(in_srcaddr),
      .rr_access(rr_access), .rr_write(in_write), .rr_datamode(in_datamode),
      .rr_ctrlmode(in_ctrlmode), .rr_dstaddr(in_dstaddr), .rr_data(in_data),
      .rr_srcaddr(in_srcaddr),
      .tx_wr_wait(tx_wr_wait), .tx_rd_wait(tx_rd_wait), .wr_progfull(wr_progfull),
      .rq_progfull(rq_progfull), .rr_progfull(rr_progfull), .wait_status(wait_status),
      .tx_frame_par(tx_frame_par), .tx_data_par(tx_data_par));

   always #5 tx_lclk_par = ~tx_lclk_par;   // 10 ns period

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic progfull_of(input chan_t c);
      return (c == CH_RR) ? rr_progfull : (c == CH_RQ) ? rq_progfull : wr_progfull;
   endfunction

   function automatic int count_in_log(input chan_t c);
      int n;
      n = 0;
      foreach (rx_log[i])
         if (rx_log[i] == c)
            n++;
      return n;
   endfunction

   // Beats are sampled at the rising edge, one cycle after they were driven
   always @(posedge tx_lclk_par)
   begin
      if (rst)
         in_beat1 = 1'b0;
      else if (tx_frame_par == FRAME_OFF && !in_beat1)
         check_data("tx_data_par", '0, tx_data_par);   // Idle link
      else
      begin
         check_frame("tx_frame_par", FRAME_ON, tx_frame_par);
         if (in_beat1)
            take_packet(beat0_hold, tx_data_par);
         beat0_hold = tx_data_par;
         in_beat1   = !in_beat1;
      end
   end

   task automatic wait_not_full(input chan_t c);
      for (int n = 0; progfull_of(c); n++)
         if (n == TMO)
            fail_stop("timeout waiting for a programmable-full flag to fall");
         else
            @(negedge tx_lclk_par);
   endtask

   task automatic wait_drain();
      for (int n = 0; !(model_empty() && !in_beat1); n++)
         if (n == TMO)
            fail_stop("timeout waiting for the queues to drain");
         else
            @(negedge tx_lclk_par);
   endtask

   task automatic wait_count(input chan_t c, input int want);
      for (int n = 0; count_in_log(c) < want; n++)
         if (n == TMO)
            fail_stop($sformatf("timeout waiting for %0d packets on channel %0d", want, c));
         else
            @(negedge tx_lclk_par);
   endtask

   // One access pulse with random fields, model updated alongside
   task automatic send_txn(input chan_t c);
      logic [31:0] rv;
      wait_not_full(c);
      rv          = lcg_next();
      in_write    = (c != CH_RQ);        // Requests go out as reads
      in_datamode = rv[1:0];
      in_ctrlmode = {c == CH_RR, rv[6:4]};  // Bit 3 tags responses
      in_dstaddr  = lcg_next();
      in_data     = lcg_next();
      in_srcaddr  = lcg_next();
      wr_access   = (c == CH_WR);
      rq_access   = (c == CH_RQ);
      rr_access   = (c == CH_RR);
      model_push(c, encode_packet(in_write, in_datamode, in_ctrlmode, in_dstaddr, in_data,
                                  in_srcaddr));
      @(negedge tx_lclk_par);
      {wr_access, rq_access, rr_access} = 3'b000;
   endtask

   // Hold one wait class, check the other class passes, then release
   task automatic hold_wait(input bit on_wr);
      tx_wr_wait = on_wr;
      tx_rd_wait = !on_wr;
      repeat (6) @(negedge tx_lclk_par);   // Settle margin
      rx_log.delete();
      repeat (2)
      begin
         send_txn(CH_WR);
         send_txn(CH_RR);
         send_txn(CH_RQ);
      end
      if (on_wr)
         wait_count(CH_RQ, 2);
      else
      begin
         wait_count(CH_WR, 2);
         wait_count(CH_RR, 2);
      end
      repeat (6) @(negedge tx_lclk_par);
      if (on_wr && count_in_log(CH_WR) + count_in_log(CH_RR) != 0)
         fail_stop("write class packet sent while wr_wait was held");
      if (!on_wr && count_in_log(CH_RQ) != 0)
         fail_stop("read request sent while rd_wait was held");
      check_flag("wait_status[1]", on_wr, wait_status[1]);
      check_flag("wait_status[0]", !on_wr, wait_status[0]);
      rx_log.delete();
      if (on_wr)
         order_exp = '{CH_RR, CH_RR, CH_WR, CH_WR};
      else
         order_exp = '{CH_RQ, CH_RQ};
      tx_wr_wait = 1'b0;
      tx_rd_wait = 1'b0;
      wait_drain();
      check_order();
   endtask

   initial
   begin
      lcg_state   = 32'h4b20;
      tx_lclk_par = 1'b0;
      rst         = 1'b1;
      tx_enable   = 1'b0;
      {wr_access, rq_access, rr_access} = 3'b000;
      {in_write, in_datamode, in_ctrlmode} = '0;
      {in_dstaddr, in_data, in_srcaddr}    = '0;
      tx_wr_wait  = 1'b0;
      tx_rd_wait  = 1'b0;
      repeat (5) @(negedge tx_lclk_par);
      rst = 1'b0;
      check_frame("tx_frame_par", FRAME_OFF, tx_frame_par);   // Reset values
      check_data("tx_data_par", '0, tx_data_par);
      check_flag("wait_status[1]", 1'b0, wait_status[1]);
      check_flag("wait_status[0]", 1'b0, wait_status[0]);
      check_flag("wr_progfull", 1'b0, wr_progfull);
      check_flag("rq_progfull", 1'b0, rq_progfull);
      check_flag("rr_progfull", 1'b0, rr_progfull);
      tx_enable = 1'b1;                  // Encoding and order on wr
      repeat (20) send_txn(CH_WR);
      wait_drain();
      check_frame("tx_frame_par", FRAME_OFF, tx_frame_par);
      tx_enable = 1'b0;                  // Priority with all queues loaded
      repeat (3)
      begin
         send_txn(CH_WR);
         send_txn(CH_RQ);
         send_txn(CH_RR);
      end
      rx_log.delete();
      order_exp = '{CH_RR, CH_RR, CH_RR, CH_RQ, CH_RQ, CH_RQ, CH_WR, CH_WR, CH_WR};
      tx_enable = 1'b1;
      wait_drain();
      check_order();
      tx_enable = 1'b0;                  // Threshold on rq
      for (int i = 1; i <= PROG_LEVEL; i++)
      begin
         send_txn(CH_RQ);
         @(negedge tx_lclk_par);
         check_flag("rq_progfull", i >= PROG_LEVEL, rq_progfull);
      end
      tx_enable = 1'b1;
      wait_drain();
      check_flag("rq_progfull", 1'b0, rq_progfull);
      hold_wait(1'b1);
      hold_wait(1'b0);
      for (int i = 0; i < 120; i++)     // Mixed traffic with wait toggling
      begin
         r = lcg_next();
         if (r[3:0] == 4'h0)
            tx_wr_wait = !tx_wr_wait;
         if (r[7:4] == 4'h0)
            tx_rd_wait = !tx_rd_wait;
         ch = (r[9:8] == 2'd2) ? CH_RR : (r[9:8] == 2'd1) ? CH_RQ : CH_WR;
         if (progfull_of(ch))
            @(negedge tx_lclk_par);      // Skip a blocked channel
         else
            send_txn(ch);
      end
      tx_wr_wait = 1'b0;
      tx_rd_wait = 1'b0;
      wait_drain();
      check_frame("tx_frame_par", FRAME_OFF, tx_frame_par);
      $display("all tests passed");
      $finish;
   end

endmodule

//--- etx_top.f
+incdir+bench
hdl/etx_emesh_pkg.sv
hdl/etx_link_pkg.sv
hdl/etx_fifo.sv
hdl/etx_arbiter.sv
hdl/etx_protocol.sv
hdl/etx_top.sv
bench/tb_etx_top.sv

//--- Bender.yml
package:
  name: etx_top

sources:
  - hdl/etx_emesh_pkg.sv
  - hdl/etx_link_pkg.sv
  - hdl/etx_fifo.sv
  - hdl/etx_arbiter.sv
  - hdl/etx_protocol.sv
  - hdl/etx_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_etx_top.sv
